// File: Makefile
SIM   = verilator
FLAGS = --binary --timing --assert
TOP   = tb_axi_bridge
FLIST = build.f

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: build.f
hw/axi_bridge_pkg.sv
hw/axi_chan_if.sv
hw/beat_counter.sv
hw/write_route_fsm.sv
hw/read_route_fsm.sv
hw/resp_route.sv
hw/decerr_target.sv
hw/axi_bridge_1x1.sv
dv/tb_axi_bridge.sv

// File: dv/tb_axi_bridge.sv
// Testbench for the single-master AXI4 address-decoding bridge.
// Drives random in-window and out-of-window bursts on the master side, answers
// the slave side with a small model, and checks every response as it arrives.

`timescale 1ns/1ps
`default_nettype none

module tb_axi_bridge;

	localparam int LIMIT = 1000;
	localparam int NUM_OPS = 48;

	logic clk;
	logic rstn;
	logic [31:0] m_awaddr_i, m_araddr_i, m_wdata_i, s_rdata_i;
	logic [3:0] m_awid_i, m_arid_i, m_wstrb_i, s_bid_i, s_rid_i;
	logic [7:0] m_awlen_i, m_arlen_i;
	logic [2:0] m_awsize_i, m_arsize_i;
	logic [1:0] m_awburst_i, m_arburst_i, s_bresp_i, s_rresp_i;
	logic m_awvalid_i, m_wlast_i, m_wvalid_i, m_bready_i, m_arvalid_i, m_rready_i;
	logic s_awready_i, s_wready_i, s_bvalid_i, s_arready_i, s_rlast_i, s_rvalid_i;
	logic m_awready_o, m_wready_o, m_bvalid_o, m_arready_o, m_rlast_o, m_rvalid_o;
	logic [3:0] m_bid_o, m_rid_o, s_awid_o, s_arid_o, s_wstrb_o;
	logic [1:0] m_bresp_o, m_rresp_o, s_awburst_o, s_arburst_o;
	logic [31:0] m_rdata_o, s_awaddr_o, s_araddr_o, s_wdata_o;
	logic [7:0] s_awlen_o, s_arlen_o;
	logic [2:0] s_awsize_o, s_arsize_o;
	logic s_awvalid_o, s_wlast_o, s_wvalid_o, s_bready_o, s_arvalid_o, s_rready_o;

	logic [31:0] lfsr;
	logic [31:0] exp_addr;
	logic [3:0] exp_id;
	logic [7:0] exp_len;
	logic [2:0] exp_size;
	logic [1:0] exp_burst;
	logic cur_in_window;
	logic [31:0] exp_w[$];
	logic [3:0] exp_strb[$];
	logic [3:0] b_pending[$];
	logic [3:0] s_aw_id;
	logic s_aw_seen, s_ar_seen, b_done, r_done, s_b_taken, s_r_taken, rd_active;
	logic [31:0] rd_addr;
	logic [7:0] rd_len;
	logic [3:0] rd_id;
	int rd_beat, s_w_count, m_beat;

	axi_bridge_1x1 DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Galois LFSR stepped once per bit handed out
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Read data returned by the slave model for a given burst beat
	function automatic logic [31:0] model_rdata(input logic [31:0] addr, input int beat);
		return (addr + 32'(beat)) ^ 32'h5a5a_0000;
	endfunction

	task automatic stop_on_error(input string what);
		$display("ERROR: %s", what);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		assert (exp == act) else begin
			$display("FAIL %s expected %h actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1);
		end
	endtask

	task automatic count_wait(inout int cycles, input string what);
		cycles++;
		if (cycles > LIMIT) begin
			stop_on_error({"timed out waiting for ", what});
		end
	endtask

	// Payloads must hold while valid waits for ready
	assert property (@(posedge clk) disable iff (!rstn) m_bvalid_o && !m_bready_i
		|=> m_bvalid_o && $stable(m_bid_o) && $stable(m_bresp_o))
		else stop_on_error("m_b dropped or changed before bready");
	assert property (@(posedge clk) disable iff (!rstn) m_rvalid_o && !m_rready_i
		|=> m_rvalid_o && $stable(m_rdata_o) && $stable(m_rid_o) && $stable(m_rresp_o)
		&& $stable(m_rlast_o))
		else stop_on_error("m_r dropped or changed before rready");
	assert property (@(posedge clk) disable iff (!rstn) s_awvalid_o && !s_awready_i
		|=> s_awvalid_o && $stable(s_awaddr_o) && $stable(s_awid_o) && $stable(s_awlen_o)
		&& $stable(s_awsize_o) && $stable(s_awburst_o))
		else stop_on_error("s_aw dropped or changed before awready");
	assert property (@(posedge clk) disable iff (!rstn) s_arvalid_o && !s_arready_i
		|=> s_arvalid_o && $stable(s_araddr_o) && $stable(s_arid_o) && $stable(s_arlen_o)
		&& $stable(s_arsize_o) && $stable(s_arburst_o))
		else stop_on_error("s_ar dropped or changed before arready");
	assert property (@(posedge clk) disable iff (!rstn) s_wvalid_o && !s_wready_i
		|=> s_wvalid_o && $stable(s_wdata_o) && $stable(s_wstrb_o) && $stable(s_wlast_o))
		else stop_on_error("s_w dropped or changed before wready");
	assert property (@(posedge clk) disable iff (!rstn)
		!((s_awvalid_o || s_arvalid_o) && !cur_in_window))
		else stop_on_error("out-of-window request reached the slave");

	// Monitor sampling every handshake on the rising edge
	always @(posedge clk) begin
		if (rstn) begin
			if (s_awvalid_o && s_awready_i) begin
				check_value("s_aw addr", exp_addr, s_awaddr_o);
				check_value("s_aw id", 32'(exp_id), 32'(s_awid_o));
				check_value("s_aw len", 32'(exp_len), 32'(s_awlen_o));
				check_value("s_aw size", 32'(exp_size), 32'(s_awsize_o));
				check_value("s_aw burst", 32'(exp_burst), 32'(s_awburst_o));
				s_aw_id = s_awid_o;
				s_aw_seen = 1'b1;
			end
			if (s_wvalid_o && s_wready_i) begin
				if (exp_w.size() == 0) begin
					stop_on_error("unexpected W beat reached the slave");
				end else begin
					check_value("s_w data", exp_w.pop_front(), s_wdata_o);
					check_value("s_w strb", 32'(exp_strb.pop_front()), 32'(s_wstrb_o));
					check_value("s_w last", 32'(s_w_count == int'(exp_len)), 32'(s_wlast_o));
					s_w_count++;
					// The slave answers only after the last beat
					if (s_wlast_o) begin
						b_pending.push_back(s_aw_id);
					end
				end
			end
			if (s_bvalid_i && s_bready_o) begin
				s_b_taken = 1'b1;
			end
			if (s_arvalid_o && s_arready_i) begin
				check_value("s_ar addr", exp_addr, s_araddr_o);
				check_value("s_ar id", 32'(exp_id), 32'(s_arid_o));
				check_value("s_ar len", 32'(exp_len), 32'(s_arlen_o));
				check_value("s_ar size", 32'(exp_size), 32'(s_arsize_o));
				check_value("s_ar burst", 32'(exp_burst), 32'(s_arburst_o));
				rd_addr = s_araddr_o;
				rd_len = s_arlen_o;
				rd_id = s_arid_o;
				rd_beat = 0;
				rd_active = 1'b1;
				s_ar_seen = 1'b1;
			end
			if (s_rvalid_i && s_rready_o) begin
				s_r_taken = 1'b1;
				rd_beat++;
				if (s_rlast_i) begin
					rd_active = 1'b0;
				end
			end
			if (m_bvalid_o && m_bready_i) begin
				check_value("m_b id", 32'(exp_id), 32'(m_bid_o));
				check_value("m_b resp", cur_in_window ? 32'd0 : 32'd3, 32'(m_bresp_o));
				b_done = 1'b1;
			end
			if (m_rvalid_o && m_rready_i) begin
				if (r_done) begin
					stop_on_error("read burst returned more beats than ARLEN+1");
				end else begin
					check_value("m_r data", cur_in_window ? model_rdata(exp_addr, m_beat)
						: 32'h0, m_rdata_o);
					check_value("m_r id", 32'(exp_id), 32'(m_rid_o));
					check_value("m_r resp", cur_in_window ? 32'd0 : 32'd3, 32'(m_rresp_o));
					check_value("m_r last", 32'(m_beat == int'(exp_len)), 32'(m_rlast_o));
					m_beat++;
					r_done = m_rlast_o;
				end
			end
		end
	end

	// Slave model and random ready gaps driven on the falling edge
	always @(negedge clk) begin
		if (rstn) begin
			s_awready_i = rand_bits(1) != 0;
			s_wready_i = rand_bits(1) != 0;
			s_arready_i = rand_bits(1) != 0;
			m_bready_i = rand_bits(1) != 0;
			m_rready_i = rand_bits(2) != 0;
			if (s_b_taken) begin
				s_bvalid_i = 1'b0;
				s_b_taken = 1'b0;
			end
			if (!s_bvalid_i && b_pending.size() > 0 && rand_bits(1) != 0) begin
				s_bid_i = b_pending.pop_front();
				s_bresp_i = 2'd0;
				s_bvalid_i = 1'b1;
			end
			if (s_r_taken) begin
				s_rvalid_i = 1'b0;
				s_r_taken = 1'b0;
			end
			if (rd_active && !s_rvalid_i && rand_bits(1) != 0) begin
				s_rdata_i = model_rdata(rd_addr, rd_beat);
				s_rid_i = rd_id;
				s_rresp_i = 2'd0;
				s_rlast_i = (rd_beat == int'(rd_len));
				s_rvalid_i = 1'b1;
			end
		end
	end

	task automatic write_burst();
		int cycles;
		logic [31:0] d;
		logic [3:0] st;
		cycles = 0;
		s_aw_seen = 1'b0;
		b_done = 1'b0;
		s_w_count = 0;
		m_awaddr_i = exp_addr;
		m_awid_i = exp_id;
		m_awlen_i = exp_len;
		m_awsize_i = exp_size;
		m_awburst_i = exp_burst;
		m_awvalid_i = 1'b1;
		do begin
			@(posedge clk);
			count_wait(cycles, "m_awready");
		end while (!m_awready_o);
		@(negedge clk);
		m_awvalid_i = 1'b0;
		for (int b = 0; b <= int'(exp_len); b++) begin
			if (rand_bits(1) != 0) begin
				@(negedge clk);
			end
			d = rand_bits(32);
			st = 4'(rand_bits(4));
			if (cur_in_window) begin
				exp_w.push_back(d);
				exp_strb.push_back(st);
			end
			m_wdata_i = d;
			m_wstrb_i = st;
			m_wlast_i = (b == int'(exp_len));
			m_wvalid_i = 1'b1;
			cycles = 0;
			do begin
				@(posedge clk);
				count_wait(cycles, "m_wready");
			end while (!m_wready_o);
			@(negedge clk);
			m_wvalid_i = 1'b0;
		end
		cycles = 0;
		while (!b_done) begin
			@(negedge clk);
			count_wait(cycles, "write response on m_b");
		end
		if (cur_in_window) begin
			check_value("s_aw seen", 32'd1, 32'(s_aw_seen));
			check_value("W beats left", 32'd0, 32'(exp_w.size()));
		end
	endtask

	task automatic read_burst();
		int cycles;
		cycles = 0;
		s_ar_seen = 1'b0;
		r_done = 1'b0;
		m_beat = 0;
		m_araddr_i = exp_addr;
		m_arid_i = exp_id;
		m_arlen_i = exp_len;
		m_arsize_i = exp_size;
		m_arburst_i = exp_burst;
		m_arvalid_i = 1'b1;
		do begin
			@(posedge clk);
			count_wait(cycles, "m_arready");
		end while (!m_arready_o);
		@(negedge clk);
		m_arvalid_i = 1'b0;
		cycles = 0;
		while (!r_done) begin
			@(negedge clk);
			count_wait(cycles, "last read beat on m_r");
		end
		if (cur_in_window) begin
			check_value("s_ar seen", 32'd1, 32'(s_ar_seen));
		end
	endtask

	initial begin
		lfsr = 32'hfe21_ed64;
		rstn = 1'b0;
		{m_awaddr_i, m_awid_i, m_awlen_i, m_awsize_i, m_awburst_i, m_awvalid_i} = '0;
		{m_wdata_i, m_wstrb_i, m_wlast_i, m_wvalid_i, m_bready_i} = '0;
		{m_araddr_i, m_arid_i, m_arlen_i, m_arsize_i, m_arburst_i, m_arvalid_i} = '0;
		m_rready_i = 1'b0;
		{s_awready_i, s_wready_i, s_bid_i, s_bresp_i, s_bvalid_i, s_arready_i} = '0;
		{s_rid_i, s_rdata_i, s_rresp_i, s_rlast_i, s_rvalid_i} = '0;
		{s_aw_seen, s_ar_seen, b_done, r_done, s_b_taken, s_r_taken, rd_active} = '0;
		{rd_addr, rd_len, rd_id, exp_addr, exp_id, exp_len} = '0;
		{exp_size, exp_burst, s_aw_id} = '0;
		{rd_beat, s_w_count, m_beat} = '0;
		cur_in_window = 1'b1;
		repeat (16) @(posedge clk);
		@(negedge clk);
		check_value("m_awready after reset", 32'd1, 32'(m_awready_o));
		check_value("m_arready after reset", 32'd1, 32'(m_arready_o));
		check_value("s_awvalid after reset", 32'd0, 32'(s_awvalid_o));
		check_value("s_arvalid after reset", 32'd0, 32'(s_arvalid_o));
		check_value("m_bvalid after reset", 32'd0, 32'(m_bvalid_o));
		check_value("m_rvalid after reset", 32'd0, 32'(m_rvalid_o));
		rstn = 1'b1;
		for (int t = 0; t < NUM_OPS; t++) begin
			cur_in_window = rand_bits(1) != 0;
			exp_addr[15:0] = 16'(rand_bits(16));
			exp_addr[31:16] = cur_in_window ? 16'h0 : (16'(rand_bits(16)) | 16'h0001);
			exp_id = 4'(rand_bits(4));
			exp_len = 8'(rand_bits(3));
			exp_size = (rand_bits(1) != 0) ? 3'd2 : 3'd1;
			exp_burst = (rand_bits(1) != 0) ? 2'd1 : 2'd0;
			if (rand_bits(1) != 0) begin
				write_burst();
			end else begin
				read_burst();
			end
		end
		$display("Test completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/axi_bridge_1x1.sv
// Top level of the AXI4 address-decoding bridge, one master and one slave.
// m_ ports face the master, s_ ports face the slave. Requests outside the
// slave window never reach the s_ side and are answered with DECERR inside.

`timescale 1ns/1ps
`default_nettype none

module axi_bridge_1x1 (
	input wire                                   clk,
	input wire                                   rstn,
	input wire  [axi_bridge_pkg::ADDR_W-1:0]     m_awaddr_i,
	input wire  [axi_bridge_pkg::ID_W-1:0]       m_awid_i,
	input wire  [axi_bridge_pkg::LEN_W-1:0]      m_awlen_i,
	input wire  [axi_bridge_pkg::SIZE_W-1:0]     m_awsize_i,
	input wire  [axi_bridge_pkg::BURST_W-1:0]    m_awburst_i,
	input wire                                   m_awvalid_i,
	output logic                                 m_awready_o,
	input wire  [axi_bridge_pkg::DATA_W-1:0]     m_wdata_i,
	input wire  [axi_bridge_pkg::STRB_W-1:0]     m_wstrb_i,
	input wire                                   m_wlast_i,
	input wire                                   m_wvalid_i,
	output logic                                 m_wready_o,
	output logic [axi_bridge_pkg::ID_W-1:0]      m_bid_o,
	output logic [1:0]                           m_bresp_o,
	output logic                                 m_bvalid_o,
	input wire                                   m_bready_i,
	input wire  [axi_bridge_pkg::ADDR_W-1:0]     m_araddr_i,
	input wire  [axi_bridge_pkg::ID_W-1:0]       m_arid_i,
	input wire  [axi_bridge_pkg::LEN_W-1:0]      m_arlen_i,
	input wire  [axi_bridge_pkg::SIZE_W-1:0]     m_arsize_i,
	input wire  [axi_bridge_pkg::BURST_W-1:0]    m_arburst_i,
	input wire                                   m_arvalid_i,
	output logic                                 m_arready_o,
	output logic [axi_bridge_pkg::ID_W-1:0]      m_rid_o,
	output logic [axi_bridge_pkg::DATA_W-1:0]    m_rdata_o,
	output logic [1:0]                           m_rresp_o,
	output logic                                 m_rlast_o,
	output logic                                 m_rvalid_o,
	input wire                                   m_rready_i,
	output logic [axi_bridge_pkg::ADDR_W-1:0]    s_awaddr_o,
	output logic [axi_bridge_pkg::ID_W-1:0]      s_awid_o,
	output logic [axi_bridge_pkg::LEN_W-1:0]     s_awlen_o,
	output logic [axi_bridge_pkg::SIZE_W-1:0]    s_awsize_o,
	output logic [axi_bridge_pkg::BURST_W-1:0]   s_awburst_o,
	output logic                                 s_awvalid_o,
	input wire                                   s_awready_i,
	output logic [axi_bridge_pkg::DATA_W-1:0]    s_wdata_o,
	output logic [axi_bridge_pkg::STRB_W-1:0]    s_wstrb_o,
	output logic                                 s_wlast_o,
	output logic                                 s_wvalid_o,
	input wire                                   s_wready_i,
	input wire  [axi_bridge_pkg::ID_W-1:0]       s_bid_i,
	input wire  [1:0]                            s_bresp_i,
	input wire                                   s_bvalid_i,
	output logic                                 s_bready_o,
	output logic [axi_bridge_pkg::ADDR_W-1:0]    s_araddr_o,
	output logic [axi_bridge_pkg::ID_W-1:0]      s_arid_o,
	output logic [axi_bridge_pkg::LEN_W-1:0]     s_arlen_o,
	output logic [axi_bridge_pkg::SIZE_W-1:0]    s_arsize_o,
	output logic [axi_bridge_pkg::BURST_W-1:0]   s_arburst_o,
	output logic                                 s_arvalid_o,
	input wire                                   s_arready_i,
	input wire  [axi_bridge_pkg::ID_W-1:0]       s_rid_i,
	input wire  [axi_bridge_pkg::DATA_W-1:0]     s_rdata_i,
	input wire  [1:0]                            s_rresp_i,
	input wire                                   s_rlast_i,
	input wire                                   s_rvalid_i,
	output logic                                 s_rready_o
);

	axi_addr_if m_aw ();
	axi_w_if    m_w ();
	axi_b_if    m_b ();
	axi_addr_if m_ar ();
	axi_r_if    m_r ();

	axi_addr_if slv_aw ();
	axi_w_if    slv_w ();
	axi_b_if    slv_b ();
	axi_addr_if slv_ar ();
	axi_r_if    slv_r ();

	// Links to the internal error target
	axi_addr_if err_aw ();
	axi_w_if    err_w ();
	axi_b_if    err_b ();
	axi_addr_if err_ar ();
	axi_r_if    err_r ();

	// Master side
	assign m_aw.addr   = m_awaddr_i;
	assign m_aw.id     = m_awid_i;
	assign m_aw.len    = m_awlen_i;
	assign m_aw.size   = m_awsize_i;
	assign m_aw.burst  = m_awburst_i;
	assign m_aw.valid  = m_awvalid_i;
	assign m_awready_o = m_aw.ready;
	assign m_w.data    = m_wdata_i;
	assign m_w.strb    = m_wstrb_i;
	assign m_w.last    = m_wlast_i;
	assign m_w.valid   = m_wvalid_i;
	assign m_wready_o  = m_w.ready;
	assign m_bid_o     = m_b.id;
	assign m_bresp_o   = m_b.resp;
	assign m_bvalid_o  = m_b.valid;
	assign m_b.ready   = m_bready_i;
	assign m_ar.addr   = m_araddr_i;
	assign m_ar.id     = m_arid_i;
	assign m_ar.len    = m_arlen_i;
	assign m_ar.size   = m_arsize_i;
	assign m_ar.burst  = m_arburst_i;
	assign m_ar.valid  = m_arvalid_i;
	assign m_arready_o = m_ar.ready;
	assign m_rid_o     = m_r.id;
	assign m_rdata_o   = m_r.data;
	assign m_rresp_o   = m_r.resp;
	assign m_rlast_o   = m_r.last;
	assign m_rvalid_o  = m_r.valid;
	assign m_r.ready   = m_rready_i;

	// Slave side
	assign s_awaddr_o   = slv_aw.addr;
	assign s_awid_o     = slv_aw.id;
	assign s_awlen_o    = slv_aw.len;
	assign s_awsize_o   = slv_aw.size;
	assign s_awburst_o  = slv_aw.burst;
	assign s_awvalid_o  = slv_aw.valid;
	assign slv_aw.ready = s_awready_i;
	assign s_wdata_o    = slv_w.data;
	assign s_wstrb_o    = slv_w.strb;
	assign s_wlast_o    = slv_w.last;
	assign s_wvalid_o   = slv_w.valid;
	assign slv_w.ready  = s_wready_i;
	assign slv_b.id     = s_bid_i;
	assign slv_b.resp   = s_bresp_i;
	assign slv_b.valid  = s_bvalid_i;
	assign s_bready_o   = slv_b.ready;
	assign s_araddr_o   = slv_ar.addr;
	assign s_arid_o     = slv_ar.id;
	assign s_arlen_o    = slv_ar.len;
	assign s_arsize_o   = slv_ar.size;
	assign s_arburst_o  = slv_ar.burst;
	assign s_arvalid_o  = slv_ar.valid;
	assign slv_ar.ready = s_arready_i;
	assign slv_r.id     = s_rid_i;
	assign slv_r.data   = s_rdata_i;
	assign slv_r.resp   = s_rresp_i;
	assign slv_r.last   = s_rlast_i;
	assign slv_r.valid  = s_rvalid_i;
	assign s_rready_o   = slv_r.ready;

	write_route_fsm u_write_route (
		.clk    (clk),
		.rstn   (rstn),
		.m_aw   (m_aw),
		.m_w    (m_w),
		.slv_aw (slv_aw),
		.err_aw (err_aw),
		.slv_w  (slv_w),
		.err_w  (err_w)
	);

	read_route_fsm u_read_route (
		.clk    (clk),
		.rstn   (rstn),
		.m_ar   (m_ar),
		.slv_ar (slv_ar),
		.err_ar (err_ar)
	);

	resp_route u_resp_route (
		.clk   (clk),
		.rstn  (rstn),
		.slv_b (slv_b),
		.err_b (err_b),
		.m_b   (m_b),
		.slv_r (slv_r),
		.err_r (err_r),
		.m_r   (m_r)
	);

	decerr_target u_decerr (
		.clk  (clk),
		.rstn (rstn),
		.aw   (err_aw),
		.w    (err_w),
		.b    (err_b),
		.ar   (err_ar),
		.r    (err_r)
	);

endmodule

`default_nettype wire

// File: hw/axi_bridge_pkg.sv
// Shared definitions for the single-master AXI4 address-decoding bridge.
// Channel widths, the fixed slave address window, the route and response
// encodings, and the address decode used by both route machines.

`default_nettype none

package axi_bridge_pkg;

	localparam int ADDR_W  = 32;
	localparam int DATA_W  = 32;
	localparam int STRB_W  = DATA_W / 8;
	localparam int ID_W    = 4;
	localparam int LEN_W   = 8;
	localparam int SIZE_W  = 3;
	localparam int BURST_W = 2;

	// Inclusive bounds of the window served by the external slave
	localparam logic [ADDR_W-1:0] SLAVE_BASE  = 32'h0000_0000;
	localparam logic [ADDR_W-1:0] SLAVE_LIMIT = 32'h0000_FFFF;

	typedef enum logic {
		TGT_SLAVE,
		TGT_DECERR
	} target_e;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'd0,
		RESP_DECERR = 2'd3
	} axi_resp_e;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_DECODE,
		ST_ISSUE,
		ST_DATA
	} route_state_e;

	// Anything outside the window goes to the internal error target
	function automatic target_e decode_target(input logic [ADDR_W-1:0] addr);
		return (addr >= SLAVE_BASE && addr <= SLAVE_LIMIT) ? TGT_SLAVE : TGT_DECERR;
	endfunction

endpackage

`default_nettype wire

// File: hw/axi_chan_if.sv
// AXI4 channel bundles that join the bridge's internal blocks.
// One address bundle serves both AW and AR. The src modport belongs to the side
// that drives valid and payload, the snk modport to the side that drives ready.

`timescale 1ns/1ps
`default_nettype none

interface axi_addr_if;
	logic [axi_bridge_pkg::ADDR_W-1:0]  addr;
	logic [axi_bridge_pkg::ID_W-1:0]    id;
	logic [axi_bridge_pkg::LEN_W-1:0]   len;
	logic [axi_bridge_pkg::SIZE_W-1:0]  size;
	logic [axi_bridge_pkg::BURST_W-1:0] burst;
	logic                               valid;
	logic                               ready;

	modport src (output addr, id, len, size, burst, valid, input ready);
	modport snk (input addr, id, len, size, burst, valid, output ready);
endinterface

interface axi_w_if;
	logic [axi_bridge_pkg::DATA_W-1:0] data;
	logic [axi_bridge_pkg::STRB_W-1:0] strb;
	logic                              last;
	logic                              valid;
	logic                              ready;

	modport src (output data, strb, last, valid, input ready);
	modport snk (input data, strb, last, valid, output ready);
endinterface

// Response channels run from target to master, so src is the target side
interface axi_b_if;
	logic [axi_bridge_pkg::ID_W-1:0] id;
	logic [1:0]                      resp;
	logic                            valid;
	logic                            ready;

	modport src (output id, resp, valid, input ready);
	modport snk (input id, resp, valid, output ready);
endinterface

interface axi_r_if;
	logic [axi_bridge_pkg::ID_W-1:0]   id;
	logic [axi_bridge_pkg::DATA_W-1:0] data;
	logic [1:0]                        resp;
	logic                              last;
	logic                              valid;
	logic                              ready;

	modport src (output id, data, resp, last, valid, input ready);
	modport snk (input id, data, resp, last, valid, output ready);
endinterface

`default_nettype wire

// File: hw/beat_counter.sv
// Burst beat counter. load_i takes a new AXI length (beats minus one),
// each step_i counts one accepted beat, and last_o marks the final beat.

`timescale 1ns/1ps
`default_nettype none

module beat_counter (
	input wire                             clk,
	input wire                             rstn,
	input wire                             load_i,
	input wire [axi_bridge_pkg::LEN_W-1:0] len_i,
	input wire                             step_i,
	output logic                           last_o
);

	logic [axi_bridge_pkg::LEN_W-1:0] len_q;
	logic [axi_bridge_pkg::LEN_W-1:0] cnt;
	logic                             active;

	assign last_o = active && (cnt == len_q);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			active <= 1'b0;
			cnt <= '0;
		end else if (load_i) begin
			active <= 1'b1;
			cnt <= '0;
		end else if (step_i) begin
			cnt <= cnt + 1'b1;
			if (last_o) begin
				active <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_i) begin
			len_q <= len_i;
		end
	end

	// After the final beat only a fresh load may start counting again
	assert property (@(posedge clk) disable iff (!rstn) step_i |-> active);

endmodule

`default_nettype wire

// File: hw/decerr_target.sv
// Internal target for requests outside the slave window.
// Writes: accepts the address, swallows the W beats, returns one DECERR B.
// Reads: returns ARLEN+1 beats of zero data with DECERR, rlast on the last.

`timescale 1ns/1ps
`default_nettype none

module decerr_target (
	input wire      clk,
	input wire      rstn,
	axi_addr_if.snk aw,
	axi_w_if.snk    w,
	axi_b_if.src    b,
	axi_addr_if.snk ar,
	axi_r_if.src    r
);

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_e;

	typedef enum logic {
		RD_IDLE,
		RD_DATA
	} rd_state_e;

	wr_state_e wr_state;
	rd_state_e rd_state;
	logic [axi_bridge_pkg::ID_W-1:0] wr_id;
	logic [axi_bridge_pkg::ID_W-1:0] rd_id;
	logic rd_load;
	logic rd_step;
	logic rd_last;

	assign aw.ready = (wr_state == WR_IDLE);
	assign w.ready  = (wr_state == WR_DATA);
	assign b.valid  = (wr_state == WR_RESP);
	assign b.id     = wr_id;
	assign b.resp   = axi_bridge_pkg::RESP_DECERR;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			wr_state <= WR_IDLE;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (aw.valid) begin
						wr_state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (w.valid && w.last) begin
						wr_state <= WR_RESP;
					end
				end
				WR_RESP: begin
					if (b.ready) begin
						wr_state <= WR_IDLE;
					end
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	assign ar.ready = (rd_state == RD_IDLE);
	assign rd_load  = ar.valid && ar.ready;
	assign rd_step  = r.valid && r.ready;

	assign r.valid = (rd_state == RD_DATA);
	assign r.id    = rd_id;
	assign r.data  = '0;
	assign r.resp  = axi_bridge_pkg::RESP_DECERR;
	assign r.last  = rd_last;

	beat_counter u_beats (
		.clk    (clk),
		.rstn   (rstn),
		.load_i (rd_load),
		.len_i  (ar.len),
		.step_i (rd_step),
		.last_o (rd_last)
	);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			rd_state <= RD_IDLE;
		end else if (rd_load) begin
			rd_state <= RD_DATA;
		end else if (rd_step && rd_last) begin
			rd_state <= RD_IDLE;
		end
	end

	// Request ids, echoed back on the responses
	always_ff @(posedge clk) begin
		if (aw.valid && aw.ready) begin
			wr_id <= aw.id;
		end
		if (rd_load) begin
			rd_id <= ar.id;
		end
	end

endmodule

`default_nettype wire

// File: hw/read_route_fsm.sv
// Read request router. Takes one AR request at a time from the master,
// decodes it against the slave window and offers it to the chosen target.
// Read data comes back through the response router, not through here.

`timescale 1ns/1ps
`default_nettype none

module read_route_fsm (
	input wire      clk,
	input wire      rstn,
	axi_addr_if.snk m_ar,
	axi_addr_if.src slv_ar,
	axi_addr_if.src err_ar
);

	axi_bridge_pkg::route_state_e state;
	axi_bridge_pkg::target_e tgt;

	logic [axi_bridge_pkg::ADDR_W-1:0]  req_addr;
	logic [axi_bridge_pkg::ID_W-1:0]    req_id;
	logic [axi_bridge_pkg::LEN_W-1:0]   req_len;
	logic [axi_bridge_pkg::SIZE_W-1:0]  req_size;
	logic [axi_bridge_pkg::BURST_W-1:0] req_burst;
	logic issue_ready;

	assign m_ar.ready = (state == axi_bridge_pkg::ST_IDLE);
	assign issue_ready = (tgt == axi_bridge_pkg::TGT_SLAVE) ? slv_ar.ready : err_ar.ready;

	assign slv_ar.addr  = req_addr;
	assign slv_ar.id    = req_id;
	assign slv_ar.len   = req_len;
	assign slv_ar.size  = req_size;
	assign slv_ar.burst = req_burst;
	assign err_ar.addr  = req_addr;
	assign err_ar.id    = req_id;
	assign err_ar.len   = req_len;
	assign err_ar.size  = req_size;
	assign err_ar.burst = req_burst;
	assign slv_ar.valid = (state == axi_bridge_pkg::ST_ISSUE) && (tgt == axi_bridge_pkg::TGT_SLAVE);
	assign err_ar.valid = (state == axi_bridge_pkg::ST_ISSUE) && (tgt == axi_bridge_pkg::TGT_DECERR);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= axi_bridge_pkg::ST_IDLE;
			tgt <= axi_bridge_pkg::TGT_SLAVE;
		end else begin
			case (state)
				axi_bridge_pkg::ST_IDLE: begin
					if (m_ar.valid) begin
						state <= axi_bridge_pkg::ST_DECODE;
					end
				end
				axi_bridge_pkg::ST_DECODE: begin
					tgt <= axi_bridge_pkg::decode_target(req_addr);
					state <= axi_bridge_pkg::ST_ISSUE;
				end
				// No data phase on the read side
				default: begin
					if (issue_ready) begin
						state <= axi_bridge_pkg::ST_IDLE;
					end
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (m_ar.valid && m_ar.ready) begin
			req_addr <= m_ar.addr;
			req_id <= m_ar.id;
			req_len <= m_ar.len;
			req_size <= m_ar.size;
			req_burst <= m_ar.burst;
		end
	end

	// Held with the same address until the target accepts
	assert property (@(posedge clk) disable iff (!rstn)
		slv_ar.valid && !slv_ar.ready |=> slv_ar.valid && $stable(slv_ar.addr));
	assert property (@(posedge clk) disable iff (!rstn)
		err_ar.valid && !err_ar.ready |=> err_ar.valid && $stable(err_ar.addr));

endmodule

`default_nettype wire

// File: hw/resp_route.sv
// Response router. Write responses from the slave and the error target go
// through a single holding slot to the master. Read data is passed through
// from whichever target raised rvalid first, locked until its last beat.

`timescale 1ns/1ps
`default_nettype none

module resp_route (
	input wire   clk,
	input wire   rstn,
	axi_b_if.snk slv_b,
	axi_b_if.snk err_b,
	axi_b_if.src m_b,
	axi_r_if.snk slv_r,
	axi_r_if.snk err_r,
	axi_r_if.src m_r
);

	logic                            b_full;
	logic [axi_bridge_pkg::ID_W-1:0] b_id;
	logic [1:0]                      b_resp;
	logic                            r_lock;
	axi_bridge_pkg::target_e         r_sel;
	logic                            r_slave;
	logic                            r_fire;

	// Slave wins a tie, so the error target waits a turn
	assign slv_b.ready = !b_full;
	assign err_b.ready = !b_full && !slv_b.valid;

	assign m_b.valid = b_full;
	assign m_b.id    = b_id;
	assign m_b.resp  = b_resp;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			b_full <= 1'b0;
		end else if (b_full) begin
			if (m_b.ready) begin
				b_full <= 1'b0;
			end
		end else if (slv_b.valid || err_b.valid) begin
			b_full <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!b_full) begin
			if (slv_b.valid) begin
				b_id <= slv_b.id;
				b_resp <= slv_b.resp;
			end else if (err_b.valid) begin
				b_id <= err_b.id;
				b_resp <= err_b.resp;
			end
		end
	end

	// Read data path, combinational once locked
	assign r_slave = (r_sel == axi_bridge_pkg::TGT_SLAVE);
	assign r_fire  = m_r.valid && m_r.ready;

	assign m_r.valid = r_lock && (r_slave ? slv_r.valid : err_r.valid);
	assign m_r.id    = r_slave ? slv_r.id : err_r.id;
	assign m_r.data  = r_slave ? slv_r.data : err_r.data;
	assign m_r.resp  = r_slave ? slv_r.resp : err_r.resp;
	assign m_r.last  = r_slave ? slv_r.last : err_r.last;
	assign slv_r.ready = r_lock && r_slave && m_r.ready;
	assign err_r.ready = r_lock && !r_slave && m_r.ready;

	always_ff @(posedge clk) begin
		if (!rstn) begin
			r_lock <= 1'b0;
			r_sel <= axi_bridge_pkg::TGT_SLAVE;
		end else if (!r_lock) begin
			if (slv_r.valid) begin
				r_lock <= 1'b1;
				r_sel <= axi_bridge_pkg::TGT_SLAVE;
			end else if (err_r.valid) begin
				r_lock <= 1'b1;
				r_sel <= axi_bridge_pkg::TGT_DECERR;
			end
		end else if (r_fire && m_r.last) begin
			r_lock <= 1'b0;
		end
	end

	// A waiting write response is never overwritten
	assert property (@(posedge clk) disable iff (!rstn)
		b_full && !m_b.ready |=> $stable(b_id) && $stable(b_resp));

endmodule

`default_nettype wire

// File: hw/write_route_fsm.sv
// Write request router. Takes one AW request at a time from the master,
// decodes it against the slave window, offers it to the chosen target and then
// passes the W burst straight through to that target until the last beat.

`timescale 1ns/1ps
`default_nettype none

module write_route_fsm (
	input wire      clk,
	input wire      rstn,
	axi_addr_if.snk m_aw,
	axi_w_if.snk    m_w,
	axi_addr_if.src slv_aw,
	axi_addr_if.src err_aw,
	axi_w_if.src    slv_w,
	axi_w_if.src    err_w
);

	axi_bridge_pkg::route_state_e state;
	axi_bridge_pkg::target_e tgt;

	logic [axi_bridge_pkg::ADDR_W-1:0]  req_addr;
	logic [axi_bridge_pkg::ID_W-1:0]    req_id;
	logic [axi_bridge_pkg::LEN_W-1:0]   req_len;
	logic [axi_bridge_pkg::SIZE_W-1:0]  req_size;
	logic [axi_bridge_pkg::BURST_W-1:0] req_burst;
	logic issue_ready;
	logic w_fire;

	assign m_aw.ready = (state == axi_bridge_pkg::ST_IDLE);
	assign issue_ready = (tgt == axi_bridge_pkg::TGT_SLAVE) ? slv_aw.ready : err_aw.ready;
	assign w_fire = m_w.valid && m_w.ready;

	// Both targets see the held request, only the chosen one sees valid
	assign slv_aw.addr  = req_addr;
	assign slv_aw.id    = req_id;
	assign slv_aw.len   = req_len;
	assign slv_aw.size  = req_size;
	assign slv_aw.burst = req_burst;
	assign err_aw.addr  = req_addr;
	assign err_aw.id    = req_id;
	assign err_aw.len   = req_len;
	assign err_aw.size  = req_size;
	assign err_aw.burst = req_burst;
	assign slv_aw.valid = (state == axi_bridge_pkg::ST_ISSUE) && (tgt == axi_bridge_pkg::TGT_SLAVE);
	assign err_aw.valid = (state == axi_bridge_pkg::ST_ISSUE) && (tgt == axi_bridge_pkg::TGT_DECERR);

	// W beats pass through once the address has been taken
	assign slv_w.data  = m_w.data;
	assign slv_w.strb  = m_w.strb;
	assign slv_w.last  = m_w.last;
	assign err_w.data  = m_w.data;
	assign err_w.strb  = m_w.strb;
	assign err_w.last  = m_w.last;
	assign slv_w.valid = m_w.valid && (state == axi_bridge_pkg::ST_DATA)
		&& (tgt == axi_bridge_pkg::TGT_SLAVE);
	assign err_w.valid = m_w.valid && (state == axi_bridge_pkg::ST_DATA)
		&& (tgt == axi_bridge_pkg::TGT_DECERR);
	assign m_w.ready = (state == axi_bridge_pkg::ST_DATA)
		&& ((tgt == axi_bridge_pkg::TGT_SLAVE) ? slv_w.ready : err_w.ready);

	always_ff @(posedge clk) begin
		if (!rstn) begin
			state <= axi_bridge_pkg::ST_IDLE;
			tgt <= axi_bridge_pkg::TGT_SLAVE;
		end else begin
			case (state)
				axi_bridge_pkg::ST_IDLE: begin
					if (m_aw.valid) begin
						state <= axi_bridge_pkg::ST_DECODE;
					end
				end
				axi_bridge_pkg::ST_DECODE: begin
					tgt <= axi_bridge_pkg::decode_target(req_addr);
					state <= axi_bridge_pkg::ST_ISSUE;
				end
				axi_bridge_pkg::ST_ISSUE: begin
					if (issue_ready) begin
						state <= axi_bridge_pkg::ST_DATA;
					end
				end
				axi_bridge_pkg::ST_DATA: begin
					if (w_fire && m_w.last) begin
						state <= axi_bridge_pkg::ST_IDLE;
					end
				end
			endcase
		end
	end

	// Request register, loaded on the master handshake
	always_ff @(posedge clk) begin
		if (m_aw.valid && m_aw.ready) begin
			req_addr <= m_aw.addr;
			req_id <= m_aw.id;
			req_len <= m_aw.len;
			req_size <= m_aw.size;
			req_burst <= m_aw.burst;
		end
	end

	// An offered request stays up until its target takes it
	assert property (@(posedge clk) disable iff (!rstn)
		slv_aw.valid && !slv_aw.ready |=> slv_aw.valid);
	assert property (@(posedge clk) disable iff (!rstn)
		err_aw.valid && !err_aw.ready |=> err_aw.valid);

endmodule

`default_nettype wire
